/* hdl/udp_axi_params.svh */
`ifndef UDP_AXI_PARAMS_SVH
`define UDP_AXI_PARAMS_SVH

// AXI and UDP word widths
`define UDP_AXI_ADDR_W   32
`define UDP_AXI_DATA_W   32
`define UDP_AXI_ID_W     2
`define UDP_AXI_LEN_W    8
`define UDP_AXI_BURST_W  2

// buffer depths in entries
`define DESC_FIFO_DEPTH  16
`define WDATA_FIFO_DEPTH 256
`define RESP_FIFO_DEPTH  16

// top byte of the first word of each frame kind
`define CMD_MARK  8'h00
`define DATA_MARK 8'hFF
`define RESP_MARK 8'hF0

`endif

/* hdl/udp_axi_pkg.sv */
`include "udp_axi_params.svh"

package udp_axi_pkg;

    // one write-address request, 44 bits
    typedef struct packed {
        logic [`UDP_AXI_ID_W-1:0]    id;
        logic [`UDP_AXI_BURST_W-1:0] burst;
        logic [`UDP_AXI_LEN_W-1:0]   len;
        logic [`UDP_AXI_ADDR_W-1:0]  addr;
    } wr_desc_t;

    // one write-data beat, 33 bits
    typedef struct packed {
        logic [`UDP_AXI_DATA_W-1:0] data;
        logic                       last;
    } wdata_beat_t;

    typedef logic [`UDP_AXI_DATA_W-1:0] udp_word_t;   // response frame word

endpackage

/* hdl/fifo_rd_if.sv */
`timescale 1ns/1ps

interface fifo_rd_if #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 16
);
    logic                       rd_en;     // pop head at clock edge
    T                           rd_data;   // head entry, valid while !empty
    logic                       empty;
    logic [$clog2(DEPTH+1)-1:0] count;     // current occupancy

    modport producer (
        input  rd_en,
        output rd_data,
        output empty,
        output count
    );

    modport consumer (
        output rd_en,
        input  rd_data,
        input  empty,
        input  count
    );

endinterface

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo
    import udp_axi_pkg::*;
#(
    parameter type T     = udp_word_t,
    parameter int  DEPTH = 16
) (
    input  logic        gmii_rx_clk,
    input  logic        rstn,
    input  logic        wr_en,
    input  T            wr_data,
    output logic        full,
    fifo_rd_if.producer rd
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;   // wrap for any depth
    endfunction

    assign do_wr      = wr_en && !full;
    assign do_rd      = rd.rd_en && !rd.empty;
    assign full       = (count == CW'(DEPTH));
    assign rd.empty   = (count == '0);
    assign rd.count   = count;
    assign rd.rd_data = mem[rd_ptr];   // fall-through head

    always_ff @(posedge gmii_rx_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CW'(do_wr) - CW'(do_rd);
        end
    end

    a_no_overflow: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        !(wr_en && full));
    a_no_underflow: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        !(rd.rd_en && rd.empty));

endmodule

/* hdl/udp_cmd_parser.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module udp_cmd_parser
    import udp_axi_pkg::*;
(
    input  logic                       gmii_rx_clk,
    input  logic                       rstn,
    input  logic                       udp_rx_en,
    input  logic [`UDP_AXI_DATA_W-1:0] udp_rx_data,
    input  logic                       udp_rx_done,
    output logic                       desc_wr_en,
    output wr_desc_t                   desc_wr_data,
    input  logic                       desc_full,
    output logic                       beat_wr_en,
    output wdata_beat_t                beat_wr_data,
    input  logic                       beat_full
);
    typedef enum logic [1:0] {ST_IDLE, ST_CMD, ST_DATA, ST_DISC} state_t;

    state_t                     state;
    logic                       addr_phase;   // next command word is an address
    logic [`UDP_AXI_DATA_W-1:0] hdr;          // last descriptor header word
    logic                       hdr_is_wr;
    logic [7:0]                 marker;
    logic                       desc_vld;
    logic                       beat_vld;

    assign marker    = udp_rx_data[31:24];
    assign hdr_is_wr = (hdr[31:24] == `CMD_MARK) && hdr[16];

    // a full FIFO loses the entry
    assign desc_wr_en = desc_vld && !desc_full;
    assign beat_wr_en = beat_vld && !beat_full;

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            state      <= ST_IDLE;
            addr_phase <= 1'b0;
            desc_vld   <= 1'b0;
            beat_vld   <= 1'b0;
        end else begin
            desc_vld <= 1'b0;
            beat_vld <= 1'b0;
            if (udp_rx_en) begin
                case (state)
                    ST_IDLE: begin
                        addr_phase <= 1'b1;   // first word is itself a header
                        if (marker == `CMD_MARK) begin
                            state <= ST_CMD;
                        end else if (marker == `DATA_MARK) begin
                            state <= ST_DATA;
                        end else begin
                            state <= ST_DISC;
                        end
                    end
                    ST_CMD: begin
                        addr_phase <= !addr_phase;
                        desc_vld   <= addr_phase && hdr_is_wr;   // reads are dropped
                    end
                    ST_DATA: beat_vld <= 1'b1;
                    default: ;
                endcase
                if (udp_rx_done) begin
                    state <= ST_IDLE;   // frame over
                end
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && (state == ST_IDLE || (state == ST_CMD && !addr_phase))) begin
            hdr <= udp_rx_data;
        end
        if (udp_rx_en && state == ST_CMD && addr_phase) begin
            desc_wr_data.id    <= hdr[21:20];
            desc_wr_data.burst <= hdr[23:22];
            desc_wr_data.len   <= hdr[15:8];
            desc_wr_data.addr  <= udp_rx_data;
        end
        if (udp_rx_en) begin
            beat_wr_data.data <= udp_rx_data;
            beat_wr_data.last <= udp_rx_done;   // last word of frame ends burst
        end
    end

    a_desc_lost: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        desc_vld |-> !desc_full)
        else $error("descriptor lost, descriptor FIFO full");
    a_beat_lost: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        beat_vld |-> !beat_full)
        else $error("write beat lost, data FIFO full");

endmodule

/* hdl/axi_aw_issuer.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module axi_aw_issuer
    import udp_axi_pkg::*;
(
    input  logic                        gmii_rx_clk,
    input  logic                        rstn,
    fifo_rd_if.consumer                 desc,
    output logic [`UDP_AXI_ID_W-1:0]    awid,
    output logic [`UDP_AXI_ADDR_W-1:0]  awaddr,
    output logic [`UDP_AXI_LEN_W-1:0]   awlen,
    output logic [`UDP_AXI_BURST_W-1:0] awburst,
    output logic                        awvalid,
    input  logic                        awready
);
    wr_desc_t desc_q;   // descriptor on the bus

    assign desc.rd_en = !awvalid && !desc.empty;   // one in flight

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            awvalid <= 1'b0;
        end else if (desc.rd_en) begin
            awvalid <= 1'b1;
        end else if (awvalid && awready) begin
            awvalid <= 1'b0;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (desc.rd_en) begin
            desc_q <= desc.rd_data;
        end
    end

    assign awid    = desc_q.id;
    assign awaddr  = desc_q.addr;
    assign awlen   = desc_q.len;
    assign awburst = desc_q.burst;

    a_aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        awvalid && !awready |=> awvalid && $stable(desc_q));

endmodule

/* hdl/axi_w_issuer.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module axi_w_issuer
    import udp_axi_pkg::*;
(
    input  logic                         gmii_rx_clk,
    input  logic                         rstn,
    fifo_rd_if.consumer                  beats,
    output logic [`UDP_AXI_DATA_W-1:0]   wdata,
    output logic [`UDP_AXI_DATA_W/8-1:0] wstrb,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready
);
    wdata_beat_t beat_q;   // output stage

    // refill when the stage is empty or drains this cycle
    assign beats.rd_en = !beats.empty && (!wvalid || wready);

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            wvalid <= 1'b0;
        end else if (beats.rd_en) begin
            wvalid <= 1'b1;
        end else if (wready) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (beats.rd_en) begin
            beat_q <= beats.rd_data;
        end
    end

    assign wdata = beat_q.data;
    assign wlast = beat_q.last;
    assign wstrb = '1;   // full-word writes only

    a_w_hold: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        wvalid && !wready |=> wvalid && $stable(beat_q));

endmodule

/* hdl/wr_resp_reporter.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module wr_resp_reporter
    import udp_axi_pkg::*;
(
    input  logic                       gmii_rx_clk,
    input  logic                       rstn,
    input  logic [`UDP_AXI_ID_W-1:0]   bid,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready,
    input  logic                       udp_tx_req,
    input  logic                       udp_tx_done,
    output logic                       udp_tx_start,
    output logic [15:0]                udp_tx_byte_num,
    output logic [`UDP_AXI_DATA_W-1:0] udp_tx_data
);
    localparam int CW = $clog2(`RESP_FIFO_DEPTH + 1);

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

    fifo_rd_if #(.T(udp_word_t), .DEPTH(`RESP_FIFO_DEPTH)) resp_rd ();

    tx_state_t     tx_state;
    logic          b_xfer;
    logic          resp_vld;     // word pending for the FIFO
    udp_word_t     resp_word;
    logic [CW-1:0] words_left;   // words still owed in this frame

    assign b_xfer = bvalid && bready;

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            bready   <= 1'b0;
            resp_vld <= 1'b0;
        end else begin
            resp_vld <= b_xfer;
            // keep room for the pending word and the one accepted now
            bready   <= (int'(resp_rd.count) + int'(resp_vld) + int'(b_xfer))
                        < `RESP_FIFO_DEPTH;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (b_xfer) begin
            resp_word <= {`RESP_MARK, 6'd0, bid, 6'd0, bresp, 8'd0};
        end
    end

    sync_fifo #(.T(udp_word_t), .DEPTH(`RESP_FIFO_DEPTH)) u_resp_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (resp_vld),
        .wr_data     (resp_word),
        .full        (),
        .rd          (resp_rd)
    );

    assign resp_rd.rd_en = (tx_state == TX_SEND) && udp_tx_req && (words_left != '0);
    assign udp_tx_data   = resp_rd.rd_data;

    always_ff @(posedge gmii_rx_clk or posedge rstn) begin
        if (rstn) begin
            tx_state        <= TX_IDLE;
            udp_tx_start    <= 1'b0;
            udp_tx_byte_num <= '0;
            words_left      <= '0;
        end else begin
            udp_tx_start <= 1'b0;
            case (tx_state)
                TX_IDLE: begin
                    if (!resp_rd.empty) begin
                        tx_state        <= TX_SEND;
                        udp_tx_start    <= 1'b1;
                        udp_tx_byte_num <= 16'(resp_rd.count) << 2;   // snapshot of count
                        words_left      <= resp_rd.count;
                    end
                end
                TX_SEND: begin
                    if (resp_rd.rd_en) begin
                        words_left <= words_left - 1'b1;
                    end
                    if (udp_tx_done) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    a_start_pulse: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        udp_tx_start |=> !udp_tx_start);

endmodule

/* hdl/udp_axi_bridge.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module udp_axi_bridge
    import udp_axi_pkg::*;
(
    input  logic                         gmii_rx_clk,
    input  logic                         rstn,
    input  logic                         udp_rx_en,
    input  logic [`UDP_AXI_DATA_W-1:0]   udp_rx_data,
    input  logic                         udp_rx_done,
    input  logic                         udp_tx_req,
    input  logic                         udp_tx_done,
    output logic                         udp_tx_start,
    output logic [15:0]                  udp_tx_byte_num,
    output logic [`UDP_AXI_DATA_W-1:0]   udp_tx_data,
    output logic [`UDP_AXI_ID_W-1:0]     awid,
    output logic [`UDP_AXI_ADDR_W-1:0]   awaddr,
    output logic [`UDP_AXI_LEN_W-1:0]    awlen,
    output logic [`UDP_AXI_BURST_W-1:0]  awburst,
    output logic                         awvalid,
    input  logic                         awready,
    output logic [`UDP_AXI_DATA_W-1:0]   wdata,
    output logic [`UDP_AXI_DATA_W/8-1:0] wstrb,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready,
    input  logic [`UDP_AXI_ID_W-1:0]     bid,
    input  logic [1:0]                   bresp,
    input  logic                         bvalid,
    output logic                         bready
);
    logic        desc_wr_en;
    wr_desc_t    desc_wr_data;
    logic        desc_full;
    logic        beat_wr_en;
    wdata_beat_t beat_wr_data;
    logic        beat_full;

    fifo_rd_if #(.T(wr_desc_t), .DEPTH(`DESC_FIFO_DEPTH))     desc_if ();
    fifo_rd_if #(.T(wdata_beat_t), .DEPTH(`WDATA_FIFO_DEPTH)) beat_if ();

    udp_cmd_parser u_parser (
        .gmii_rx_clk  (gmii_rx_clk),
        .rstn         (rstn),
        .udp_rx_en    (udp_rx_en),
        .udp_rx_data  (udp_rx_data),
        .udp_rx_done  (udp_rx_done),
        .desc_wr_en   (desc_wr_en),
        .desc_wr_data (desc_wr_data),
        .desc_full    (desc_full),
        .beat_wr_en   (beat_wr_en),
        .beat_wr_data (beat_wr_data),
        .beat_full    (beat_full)
    );

    sync_fifo #(.T(wr_desc_t), .DEPTH(`DESC_FIFO_DEPTH)) u_desc_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (desc_wr_en),
        .wr_data     (desc_wr_data),
        .full        (desc_full),
        .rd          (desc_if)
    );

    sync_fifo #(.T(wdata_beat_t), .DEPTH(`WDATA_FIFO_DEPTH)) u_beat_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wr_en       (beat_wr_en),
        .wr_data     (beat_wr_data),
        .full        (beat_full),
        .rd          (beat_if)
    );

    axi_aw_issuer u_aw (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .desc        (desc_if),
        .awid        (awid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awburst     (awburst),
        .awvalid     (awvalid),
        .awready     (awready)
    );

    axi_w_issuer u_w (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .beats       (beat_if),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready)
    );

    wr_resp_reporter u_resp (
        .gmii_rx_clk     (gmii_rx_clk),
        .rstn            (rstn),
        .bid             (bid),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .udp_tx_req      (udp_tx_req),
        .udp_tx_done     (udp_tx_done),
        .udp_tx_start    (udp_tx_start),
        .udp_tx_byte_num (udp_tx_byte_num),
        .udp_tx_data     (udp_tx_data)
    );

endmodule

/* verif/tb_udp_axi_bridge.sv */
`timescale 1ns/1ps
`include "udp_axi_params.svh"

module tb_udp_axi_bridge
    import udp_axi_pkg::*;
();
    logic        gmii_rx_clk;
    logic        rstn;
    logic        udp_rx_en;
    logic [31:0] udp_rx_data;
    logic        udp_rx_done;
    logic        udp_tx_req;
    logic        udp_tx_done;
    logic        udp_tx_start;
    logic [15:0] udp_tx_byte_num;
    logic [31:0] udp_tx_data;
    logic [1:0]  awid;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bid;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;

    wr_desc_t    exp_desc[$];   // write-address transfers still owed
    wdata_beat_t exp_beat[$];
    logic [31:0] exp_resp[$];   // response words still owed
    logic [31:0] frame[$];      // frame under construction
    logic [1:0]  wr_ids[$];     // issued ids awaiting a response
    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic        sending;

    udp_axi_bridge uut (.*);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #2 gmii_rx_clk = ~gmii_rx_clk;
    end

    function automatic logic [31:0] lcg_next(inout logic [31:0] s);
        s = s * 32'd1664525 + 32'd1013904223;
        return s;
    endfunction

    task automatic end_with_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_with_note(input string msg);
        $display("error at %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // random back-pressure on both AXI ready inputs
    always @(negedge gmii_rx_clk) begin : ready_drive
        logic [31:0] r;
        r = lcg_next(ready_state);
        awready = (r[31:30] != 2'b00);
        wready  = (r[29:28] != 2'b00);
    end

    always @(posedge gmii_rx_clk) begin : aw_monitor
        wr_desc_t d;
        if (!rstn && awvalid && awready) begin
            if (exp_desc.size() == 0) begin
                fail_with_note("write-address transfer without a matching write descriptor");
            end else begin
                d = exp_desc.pop_front();
                check_eq("awid", 32'(d.id), 32'(awid));
                check_eq("awburst", 32'(d.burst), 32'(awburst));
                check_eq("awlen", 32'(d.len), 32'(awlen));
                check_eq("awaddr", d.addr, awaddr);
                wr_ids.push_back(d.id);
            end
        end
    end

    always @(posedge gmii_rx_clk) begin : w_monitor
        wdata_beat_t b;
        if (!rstn && wvalid && wready) begin
            if (exp_beat.size() == 0) begin
                fail_with_note("write-data beat that no data frame carried");
            end else begin
                b = exp_beat.pop_front();
                check_eq("wdata", b.data, wdata);
                check_eq("wlast", 32'(b.last), 32'(wlast));
                check_eq("wstrb", 32'hf, 32'(wstrb));
            end
        end
    end

    a_aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        awvalid && !awready |=> awvalid && $stable({awid, awaddr, awlen, awburst}))
        else fail_with_note("write-address channel changed before its transfer");
    a_w_hold: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        wvalid && !wready |=> wvalid && $stable({wdata, wstrb, wlast}))
        else fail_with_note("write-data channel changed before its transfer");
    a_start_pulse: assert property (@(posedge gmii_rx_clk) disable iff (rstn)
        udp_tx_start |=> !udp_tx_start)
        else fail_with_note("udp_tx_start stayed high for more than one cycle");

    // udp transmit side sends one req per word then done
    initial begin : udp_sender
        int          n;
        logic [15:0] bn;
        sending = 1'b0;
        forever begin
            @(posedge gmii_rx_clk);
            if (!rstn && udp_tx_start) begin
                bn = udp_tx_byte_num;
                n  = int'(bn) / 4;
                sending = 1'b1;
                check_eq("udp_tx_byte_num[1:0]", 32'h0, 32'(bn[1:0]));
                if (n == 0 || n > exp_resp.size()) begin
                    fail_with_note("response frame size does not match pending responses");
                end
                for (int i = 0; i < n; i++) begin
                    @(negedge gmii_rx_clk);
                    udp_tx_req = 1'b1;
                    check_eq("udp_tx_data", exp_resp.pop_front(), udp_tx_data);
                end
                @(negedge gmii_rx_clk);
                udp_tx_req  = 1'b0;
                udp_tx_done = 1'b1;
                check_eq("udp_tx_byte_num", 32'(bn), 32'(udp_tx_byte_num));   // held to done
                @(negedge gmii_rx_clk);
                udp_tx_done = 1'b0;
                sending     = 1'b0;
            end
        end
    end

    task automatic add_desc(input logic is_wr);
        logic [31:0] r;
        logic [31:0] hdr;
        wr_desc_t    d;
        r       = lcg_next(stim_state);
        d.id    = r[1:0];
        d.burst = r[3:2];
        d.len   = r[11:4];
        d.addr  = lcg_next(stim_state);
        hdr        = '0;
        hdr[31:24] = `CMD_MARK;
        hdr[23:22] = d.burst;
        hdr[21:20] = d.id;
        hdr[19:17] = r[14:12];   // unused bits carry noise
        hdr[16]    = is_wr;
        hdr[15:8]  = d.len;
        hdr[7:0]   = r[22:15];
        frame.push_back(hdr);
        frame.push_back(d.addr);
        if (is_wr) begin
            exp_desc.push_back(d);
        end
    endtask

    task automatic add_data_frame(input int n);
        logic [31:0] r;
        wdata_beat_t b;
        r = lcg_next(stim_state);
        frame.push_back({`DATA_MARK, r[23:0]});
        for (int i = 0; i < n; i++) begin
            b.data = lcg_next(stim_state);
            b.last = (i == n - 1);
            frame.push_back(b.data);
            exp_beat.push_back(b);
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < frame.size(); i++) begin
            @(negedge gmii_rx_clk);
            udp_rx_en   = 1'b1;
            udp_rx_data = frame[i];
            udp_rx_done = (i == frame.size() - 1);
        end
        @(negedge gmii_rx_clk);
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        frame.delete();
    endtask

    // one B response per issued write with random gaps
    task automatic answer_writes();
        logic [31:0] r;
        logic [31:0] word;
        int          cyc;
        while (wr_ids.size() != 0) begin
            r = lcg_next(stim_state);
            repeat (r[18:16]) @(negedge gmii_rx_clk);
            @(negedge gmii_rx_clk);
            bvalid = 1'b1;
            bid    = wr_ids.pop_front();
            bresp  = r[9:8];
            cyc    = 0;
            @(posedge gmii_rx_clk);
            while (!bready) begin
                cyc++;
                if (cyc > 200) begin
                    fail_with_note("bready never rose for a pending write response");
                end
                @(posedge gmii_rx_clk);
            end
            word        = '0;
            word[31:24] = `RESP_MARK;
            word[17:16] = bid;
            word[9:8]   = bresp;
            exp_resp.push_back(word);
            @(negedge gmii_rx_clk);
            bvalid = 1'b0;
        end
    endtask

    task automatic wait_drained(input string what, input bit with_resp);
        int cyc;
        cyc = 0;
        while (exp_desc.size() != 0 || exp_beat.size() != 0
               || (with_resp && (exp_resp.size() != 0 || sending))) begin
            @(negedge gmii_rx_clk);
            cyc++;
            if (cyc > 4000) begin
                fail_with_note(what);
            end
        end
    endtask

    initial begin : main_seq
        udp_rx_en   = 1'b0;
        udp_rx_data = '0;
        udp_rx_done = 1'b0;
        udp_tx_req  = 1'b0;
        udp_tx_done = 1'b0;
        awready     = 1'b0;
        wready      = 1'b0;
        bid         = '0;
        bresp       = '0;
        bvalid      = 1'b0;
        stim_state  = 32'hea58;
        ready_state = lcg_next(stim_state);
        rstn        = 1'b1;
        repeat (5) @(posedge gmii_rx_clk);
        @(negedge gmii_rx_clk);
        check_eq("bready", 32'h0, 32'(bready));
        check_eq("awvalid", 32'h0, 32'(awvalid));
        rstn = 1'b0;
        repeat (4) @(negedge gmii_rx_clk);   // idle window before any frame
        check_eq("awvalid", 32'h0, 32'(awvalid));
        check_eq("wvalid", 32'h0, 32'(wvalid));
        check_eq("udp_tx_start", 32'h0, 32'(udp_tx_start));
        check_eq("udp_tx_byte_num", 32'h0, 32'(udp_tx_byte_num));

        for (int round = 0; round < 3; round++) begin
            add_desc(1'b1);
            add_desc(1'b0);   // read descriptor is dropped
            add_desc(1'b1);
            send_frame();
            add_data_frame(3 + round * 4);
            send_frame();
            wait_drained("write channels stalled with transfers still expected", 1'b0);
            answer_writes();
        end
        wait_drained("response frames stalled with words still expected", 1'b1);

        if (!awvalid && !wvalid && !udp_tx_start) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_with_note("DUT still presents a transfer after all expected traffic completed");
        end
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/udp_axi_pkg.sv
hdl/fifo_rd_if.sv
hdl/sync_fifo.sv
hdl/udp_cmd_parser.sv
hdl/axi_aw_issuer.sv
hdl/axi_w_issuer.sv
hdl/wr_resp_reporter.sv
hdl/udp_axi_bridge.sv
verif/tb_udp_axi_bridge.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_udp_axi_bridge -f filelist.f -o tb_sim \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/tb_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
